//--- testbench/gpio_in_input.txt
# P pins(hex) hold(dec) | W addr(hex) data(hex) | R addr(hex) expected(hex)
# I expected_irq ; addr 0 level, 1 events, 2 irq enable, 3 reserved
P 00 8
R 0 00
R 1 00
I 0
# all pins high, bit 7 dead, rising events on bits 0-3
P FF 8
R 0 7F
R 1 0F
I 0
W 1 0F
R 1 00
# all pins low, falling events on bits 2-5
P 00 8
R 0 00
R 1 3C
# bits 6 and 7 never raise events
P 40 8
R 0 40
P 00 8
P 80 8
R 0 00
R 1 3C
# partial clear keeps the rest
W 1 0C
R 1 30
# interrupt enable on bit 4
I 0
W 2 10
R 2 10
I 1
W 1 10
I 0
R 1 20
# level and reserved writes change nothing
W 0 FF
R 0 00
W 3 FF
R 3 00
R 2 10
# both edges on bits 2-3, falls only on 4-5
W 1 FF
R 1 00
P 0C 8
R 1 0C
W 1 0C
P 00 8
R 1 0C
P 30 8
R 1 0C
P 03 8
R 0 03
R 1 3F
# enable bit 5 then mask it again
W 2 20
I 1
W 2 00
I 0
R 2 00

//--- gpio_in_top.f
+incdir+include
rtl/gpio_io_pkg.sv
rtl/gpio_bus_pkg.sv
rtl/in_cond.sv
rtl/event_capture.sv
rtl/gpio_regs.sv
rtl/gpio_in_top.sv
testbench/gpio_in_tb.sv

//--- Bender.yml
package:
  name: gpio_in

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/gpio_io_pkg.sv
      - rtl/gpio_bus_pkg.sv
      - rtl/in_cond.sv
      - rtl/event_capture.sv
      - rtl/gpio_regs.sv
      - rtl/gpio_in_top.sv

  - target: simulation
    files:
      - testbench/gpio_in_tb.sv

//--- testbench/gpio_in_tb.sv
/* file-driven testbench for gpio_in_top; commands come from testbench/gpio_in_input.txt
   run from the project root; every action starts 1 ns after a rising edge */

`timescale 1ns/1ps

module gpio_in_tb;

	logic                    clk_i;			// 8 ns clock
	logic                    rst_i;			// async reset, active high
	gpio_io_pkg::gpio_data_t pins_i;		// raw pins to the DUT
	gpio_bus_pkg::bus_req_t  bus_req_i;		// host request
	gpio_bus_pkg::bus_resp_t bus_resp_o;	// slave response
	logic                    irq_o;			// interrupt

	logic [7:0] cmd_kind[$];	// P, W, R or I
	int         cmd_a[$];		// pins, addr or expected irq
	int         cmd_b[$];		// hold, wdata or expected rdata

	int cycles;			// edges since start
	int cycle_limit;	// 0 until the command list is loaded

	gpio_in_top UUT (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pins_i     (pins_i),
		.bus_req_i  (bus_req_i),
		.bus_resp_o (bus_resp_o),
		.irq_o      (irq_o)
	);

	always #4 clk_i = ~clk_i;	// 8 ns period

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			fail_stop($sformatf("timeout, the run went past %0d cycles", cycle_limit));
		end
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(input string name, input gpio_io_pkg::gpio_data_t got,
			input gpio_io_pkg::gpio_data_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			fail_stop($sformatf("[ERROR] irq_o: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic step();
		@(posedge clk_i);
		#1;	// drive and sample away from the edge
	endtask

	// full four-phase access with ack timing checks
	task automatic bus_cycle(input logic we, input gpio_bus_pkg::reg_addr_t addr,
			input gpio_io_pkg::gpio_data_t wdata, output gpio_io_pkg::gpio_data_t rdata);
		int edges;
		if (bus_resp_o.ack) begin
			fail_stop("ack was already high before the request started");
		end
		bus_req_i.req   = 1'b1;
		bus_req_i.we    = we;
		bus_req_i.addr  = addr;
		bus_req_i.wdata = wdata;
		edges = 0;
		while (!bus_resp_o.ack && edges < 4) begin	// bounded wait for ack
			step();
			edges++;
		end
		if (edges != 1) begin
			fail_stop($sformatf("ack did not rise one edge after req (waited %0d)", edges));
		end
		rdata = bus_resp_o.rdata;	// valid while ack is high
		step();	// req held one more cycle, slave stays in ack
		if (!bus_resp_o.ack) begin
			fail_stop("ack fell while req was still high");
		end
		bus_req_i = '0;
		edges = 0;
		while (bus_resp_o.ack && edges < 4) begin
			step();
			edges++;
		end
		if (edges != 1) begin
			fail_stop($sformatf("ack did not fall one edge after req dropped (waited %0d)",
				edges));
		end
	endtask

	task automatic bus_write(input gpio_bus_pkg::reg_addr_t addr,
			input gpio_io_pkg::gpio_data_t wdata);
		gpio_io_pkg::gpio_data_t unused;
		bus_cycle(1'b1, addr, wdata, unused);
	endtask

	task automatic bus_read(input gpio_bus_pkg::reg_addr_t addr,
			output gpio_io_pkg::gpio_data_t rdata);
		bus_cycle(1'b0, addr, '0, rdata);
	endtask

	// parse the whole file first so the timeout is known up front
	task automatic load_commands();
		int         fd;
		int         n;
		int         ch;
		int         a;
		int         b;
		int         hold_sum;
		int         bus_cnt;
		logic [7:0] kind;
		logic       done;
		fd = $fopen("testbench/gpio_in_input.txt", "r");
		if (fd == 0) begin
			fail_stop("could not open testbench/gpio_in_input.txt");
		end
		hold_sum = 0;
		bus_cnt  = 0;
		done     = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %c", kind);	// first non-blank char of a line
			if (n != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin	// skip comment line
					ch = $fgetc(fd);
				end
			end else begin
				a = 0;
				b = 0;
				case (kind)
					"P": n = $fscanf(fd, "%h %d", a, b) - 2;
					"W", "R": n = $fscanf(fd, "%h %h", a, b) - 2;
					"I": n = $fscanf(fd, "%h", a) - 1;
					default: fail_stop($sformatf("unknown command '%c' in data file", kind));
				endcase
				if (n != 0) begin
					fail_stop($sformatf("malformed '%c' line in data file", kind));
				end
				if (kind == "P") begin
					if (b < 5) begin
						fail_stop("a pin line holds for fewer than 5 cycles");
					end
					hold_sum += b;
				end else if (kind != "I") begin
					bus_cnt++;
				end
				cmd_kind.push_back(kind);
				cmd_a.push_back(a);
				cmd_b.push_back(b);
			end
		end
		$fclose(fd);
		cycle_limit = 20 * hold_sum + 10 * bus_cnt;
	endtask

	task automatic run_command(input int k);
		gpio_io_pkg::gpio_data_t rdata;
		case (cmd_kind[k])
			"P": begin
				pins_i = gpio_io_pkg::gpio_data_t'(cmd_a[k]);
				repeat (cmd_b[k]) step();	// let sync and events settle
			end
			"W": bus_write(gpio_bus_pkg::reg_addr_t'(cmd_a[k]),
				gpio_io_pkg::gpio_data_t'(cmd_b[k]));
			"R": begin
				bus_read(gpio_bus_pkg::reg_addr_t'(cmd_a[k]), rdata);
				check_data($sformatf("bus_resp_o.rdata (addr %0d)", cmd_a[k]), rdata,
					gpio_io_pkg::gpio_data_t'(cmd_b[k]));
			end
			default: check_irq(irq_o, cmd_a[k][0]);	// I line
		endcase
	endtask

	initial begin
		int k;
		clk_i       = 1'b0;
		rst_i       = 1'b1;
		pins_i      = '0;
		bus_req_i   = '0;
		cycles      = 0;
		cycle_limit = 0;
		load_commands();
		repeat (3) @(posedge clk_i);	// 3 cycles of reset
		#1;
		rst_i = 1'b0;
		for (k = 0; k < cmd_kind.size(); k++) begin
			run_command(k);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- rtl/gpio_in_top.sv
/* input block top: resync and mask pins, detect edges, capture events,
   expose levels/events/enable over the req/ack bus and drive one interrupt
   pins_i is asynchronous; everything else is in the clk_i domain */

`timescale 1ns/1ps

`include "gpio_in_settings.svh"

module gpio_in_top (
	input  logic                    clk_i,		// clock
	input  logic                    rst_i,		// async reset, active high
	input  gpio_io_pkg::gpio_data_t pins_i,		// raw pins
	input  gpio_bus_pkg::bus_req_t  bus_req_i,	// host request
	output gpio_bus_pkg::bus_resp_t bus_resp_o,	// host response
	output logic                    irq_o		// any enabled event
);

	gpio_io_pkg::gpio_data_t level;		// synchronized, masked levels
	gpio_io_pkg::gpio_data_t edges;		// one-cycle edge pulses
	gpio_io_pkg::gpio_data_t events;	// sticky events
	gpio_io_pkg::gpio_data_t evt_clr;	// write-1-to-clear pulse

	// level path: mask dead pins, resync live ones, no edges
	in_cond #(
		.DATA_W    (`GPIO_DATA_W),
		.SYNC_W    (`GPIO_SYNC_W),
		.LIVE_MASK (`GPIO_LIVE_MASK),
		.SYNC_MASK ('1),
		.RISE_MASK ('0),
		.FALL_MASK ('0)
	) u_level_cond (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (pins_i),
		.data_o (level)
	);

	// event path: already synchronous, only edge-sensitive bits live
	in_cond #(
		.DATA_W    (`GPIO_DATA_W),
		.SYNC_W    (`GPIO_SYNC_W),
		.LIVE_MASK (`GPIO_RISE_MASK | `GPIO_FALL_MASK),
		.SYNC_MASK ('0),
		.RISE_MASK (`GPIO_RISE_MASK),
		.FALL_MASK (`GPIO_FALL_MASK)
	) u_edge_cond (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (level),
		.data_o (edges)
	);

	event_capture u_event_capture (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.edge_i   (edges),
		.clr_i    (evt_clr),
		.events_o (events)
	);

	gpio_regs u_gpio_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.bus_req_i  (bus_req_i),
		.bus_resp_o (bus_resp_o),
		.level_i    (level),
		.events_i   (events),
		.evt_clr_o  (evt_clr),
		.irq_o      (irq_o)
	);

endmodule

//--- rtl/gpio_regs.sv
/* four-phase req/ack register slave with event clear and interrupt enable
   ack rises one edge after req is sampled in idle; one access in flight only
   rdata is valid only while ack is high */

`timescale 1ns/1ps

module gpio_regs (
	input  logic                     clk_i,		// clock
	input  logic                     rst_i,		// async active-high reset
	input  gpio_bus_pkg::bus_req_t   bus_req_i,	// host request
	output gpio_bus_pkg::bus_resp_t  bus_resp_o,	// ack and read data
	input  gpio_io_pkg::gpio_data_t  level_i,		// synchronized pin levels
	input  gpio_io_pkg::gpio_data_t  events_i,		// sticky events
	output gpio_io_pkg::gpio_data_t  evt_clr_o,		// event clear pulse
	output logic                     irq_o			// registered interrupt
);

	gpio_bus_pkg::slave_state_e state_q;	// slave FSM
	gpio_io_pkg::gpio_data_t    irq_en_q;	// interrupt enable register
	gpio_io_pkg::gpio_data_t    rdata_q;	// latched read data
	gpio_io_pkg::gpio_data_t    rd_mux;		// decoded read value
	logic                       access;		// access accepted this cycle
	logic                       irq_q;		// interrupt flop

	// req sampled in idle starts the access; effects land at the ack edge
	assign access = (state_q == gpio_bus_pkg::S_IDLE) && bus_req_i.req;

	always_comb begin
		case (bus_req_i.addr)
			gpio_bus_pkg::REG_LEVEL:  rd_mux = level_i;
			gpio_bus_pkg::REG_EVENT:  rd_mux = events_i;
			gpio_bus_pkg::REG_IRQ_EN: rd_mux = irq_en_q;
			default:                  rd_mux = '0;	// reserved word
		endcase
	end

	// clear pulse is combinational so events drop at the same edge as ack rises
	assign evt_clr_o = (access && bus_req_i.we && (bus_req_i.addr == gpio_bus_pkg::REG_EVENT)) ?
	                   bus_req_i.wdata : '0;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_q <= gpio_bus_pkg::S_IDLE;
		end else begin
			case (state_q)
				gpio_bus_pkg::S_IDLE: begin
					if (bus_req_i.req) begin
						state_q <= gpio_bus_pkg::S_ACK;	// ack next edge
					end
				end
				gpio_bus_pkg::S_ACK: begin
					if (!bus_req_i.req) begin
						state_q <= gpio_bus_pkg::S_IDLE;	// host let go so ack drops
					end
				end
				default: state_q <= gpio_bus_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			irq_en_q <= '0;	// all interrupts masked
		end else if (access && bus_req_i.we && (bus_req_i.addr == gpio_bus_pkg::REG_IRQ_EN)) begin
			irq_en_q <= bus_req_i.wdata;
		end
	end

	// read value captured at the edge that raises ack
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			rdata_q <= '0;
		end else if (access) begin
			rdata_q <= rd_mux;
		end
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= |(events_i & irq_en_q);	// any enabled event
		end
	end

	always_comb begin
		bus_resp_o.ack   = (state_q == gpio_bus_pkg::S_ACK);
		bus_resp_o.rdata = rdata_q;
	end

	assign irq_o = irq_q;

	// ack only ever answers a request seen on the previous edge
	a_ack_needs_req : assert property (
		@(posedge clk_i) disable iff (rst_i)
		$rose(bus_resp_o.ack) |-> $past(bus_req_i.req)
	) else $error("gpio_regs: ack rose without req");

	// host holds the request steady until it sees ack
	a_req_stable : assert property (
		@(posedge clk_i) disable iff (rst_i)
		(bus_req_i.req && !bus_resp_o.ack) |=> (bus_req_i.req && $stable(bus_req_i))
	) else $error("gpio_regs: request changed before ack");

endmodule

//--- rtl/event_capture.sv
/* sticky event register, one bit per pin
   a set and a clear in the same cycle leave the bit set */

`timescale 1ns/1ps

module event_capture (
	input  logic                    clk_i,		// clock
	input  logic                    rst_i,		// async reset, active high
	input  gpio_io_pkg::gpio_data_t edge_i,		// edge pulses, one cycle each
	input  gpio_io_pkg::gpio_data_t clr_i,		// write-1-to-clear pulse from bus
	output gpio_io_pkg::gpio_data_t events_o	// sticky event bits
);

	gpio_io_pkg::gpio_data_t events_q;	// event state
	gpio_io_pkg::gpio_data_t events_d;	// next state

	// clear first, then set, so a new edge is never lost
	always_comb begin
		events_d = (events_q & ~clr_i) | edge_i;
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			events_q <= '0;	// no events after reset
		end else begin
			events_q <= events_d;
		end
	end

	assign events_o = events_q;

	// an edge pulse is always visible in the event bits one cycle later,
	// even when the host clears the same bit in that cycle
	a_edge_sets_event : assert property (
		@(posedge clk_i) disable iff (rst_i)
		(edge_i != '0) |=> ((events_o & $past(edge_i)) == $past(edge_i))
	) else $error("event_capture: edge pulse did not set its event bit");

endmodule

//--- rtl/in_cond.sv
/* per-bit input conditioning where dead bits read zero and live bits are optionally
   resynced through SYNC_W flops and optionally turned into edge pulses
   edge pulses are combinational from the conditioned bit and its delayed copy */

`timescale 1ns/1ps

module in_cond #(
	parameter int              DATA_W    = 8,	// data width
	parameter int              SYNC_W    = 2,	// resync depth of at least 1
	parameter logic [DATA_W-1:0] LIVE_MASK = '1,	// 1 marks a live bit and 0 a dead one
	parameter logic [DATA_W-1:0] SYNC_MASK = '0,	// 1=resync this bit
	parameter logic [DATA_W-1:0] RISE_MASK = '0,	// 1=pulse on rising edge
	parameter logic [DATA_W-1:0] FALL_MASK = '0	// 1=pulse on falling edge
) (
	input  logic              clk_i,	// clock
	input  logic              rst_i,	// async active-high reset
	input  logic [DATA_W-1:0] data_i,	// raw or synchronized input
	output logic [DATA_W-1:0] data_o	// conditioned output
);

	genvar i;

	for (i = 0; i < DATA_W; i++) begin : g_bit
		if (LIVE_MASK[i]) begin : g_live
			logic cur;	// bit after optional resync

			if (SYNC_MASK[i]) begin : g_sync
				logic [SYNC_W-1:0] sync_q;	// shift chain with oldest sample at msb

				always_ff @(posedge clk_i or posedge rst_i) begin
					if (rst_i) begin
						sync_q <= '0;
					end else begin
						sync_q <= (sync_q << 1) | SYNC_W'(data_i[i]);	// new sample enters at lsb
					end
				end
				assign cur = sync_q[SYNC_W-1];
			end else begin : g_nosync
				assign cur = data_i[i];	// already in clock domain
			end

			if (RISE_MASK[i] || FALL_MASK[i]) begin : g_edge
				logic prev_q;	// one-cycle delayed copy

				always_ff @(posedge clk_i or posedge rst_i) begin
					if (rst_i) begin
						prev_q <= 1'b0;
					end else begin
						prev_q <= cur;
					end
				end

				// both masks set gives a pulse on any change
				assign data_o[i] = (RISE_MASK[i] & cur & ~prev_q) |
				                   (FALL_MASK[i] & ~cur & prev_q);
			end else begin : g_level
				assign data_o[i] = cur;	// plain level
			end
		end else begin : g_dead
			assign data_o[i] = 1'b0;	// dead bit
		end
	end

	// a zero-depth chain would leave the sync path undriven
	a_sync_w_min : assert property (@(posedge clk_i) SYNC_W >= 1)
		else $error("in_cond: SYNC_W must be at least 1");

endmodule

//--- rtl/gpio_bus_pkg.sv
/* host bus types for the four-phase req/ack slave
   one access at a time; no byte enables, no error response */

package gpio_bus_pkg;

	// register address, four words
	typedef logic [1:0] reg_addr_t;

	// register map, address 3 is reserved (reads zero, writes ignored)
	localparam reg_addr_t REG_LEVEL  = 2'd0;	// synchronized pin levels, read only
	localparam reg_addr_t REG_EVENT  = 2'd1;	// sticky events, write 1 to clear
	localparam reg_addr_t REG_IRQ_EN = 2'd2;	// interrupt enable, read/write

	// host to slave, held stable until ack
	typedef struct packed {
		logic                    req;	// access request
		logic                    we;	// 1=write, 0=read
		reg_addr_t               addr;	// register select
		gpio_io_pkg::gpio_data_t wdata;	// write data
	} bus_req_t;

	// slave to host
	typedef struct packed {
		logic                    ack;	// access done, held until req drops
		gpio_io_pkg::gpio_data_t rdata;	// valid while ack is high
	} bus_resp_t;

	// bus slave FSM
	typedef enum logic {
		S_IDLE = 1'b0,	// waiting for req
		S_ACK  = 1'b1	// ack high, waiting for req to drop
	} slave_state_e;

endpackage

//--- rtl/gpio_io_pkg.sv
/* pin-side types, sized from the settings header
   one vector type serves levels, events, enables and bus data */

package gpio_io_pkg;

`include "gpio_in_settings.svh"

	// pin data vector
	// same width for the level, event, enable and clear paths
	typedef logic [`GPIO_DATA_W-1:0] gpio_data_t;

endpackage

//--- include/gpio_in_settings.svh
/* build-time settings for the input block; masks are GPIO_DATA_W bits wide
   a bit must be live in GPIO_LIVE_MASK before its edge masks mean anything */

`ifndef GPIO_IN_SETTINGS_SVH
`define GPIO_IN_SETTINGS_SVH

// pin count and data width of every register
`define GPIO_DATA_W 8

// resync flops on the level path, 1 min
`define GPIO_SYNC_W 2

// live pins, bit 7 is dead and reads zero
`define GPIO_LIVE_MASK 8'h7F

// edge selection per bit
// 0-1 rise only, 2-3 both edges, 4-5 fall only, 6-7 no events
`define GPIO_RISE_MASK 8'h0F
`define GPIO_FALL_MASK 8'h3C

`endif
